/* tomasulo_pkg.sv */
`default_nettype none

package tomasulo_pkg;

  // cluster sizing, overridden from the top level
  localparam int DEFAULT_NUM_LANES = 3;
  localparam int DEFAULT_RS_DEPTH  = 3;

  // reorder buffer of 8 entries
  typedef logic [2:0] rob_tag_t;

  // operand and result word
  typedef logic signed [31:0] word_t;

  // shift amount, low bits of operand 2
  typedef logic [4:0] shamt_t;

  // alu function codes as issued by the front end
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,  // signed compare, 1 or 0
    ALU_SLTU = 4'd6,  // unsigned compare, 1 or 0
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

endpackage

`default_nettype wire

/* rs_issue_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one renamed instruction from the router into a station
interface rs_issue_if;
  import tomasulo_pkg::*;

  logic     valid;    // one-cycle strobe, accepted at this edge
  rob_tag_t q_i;      // producer tag when i is not ready
  rob_tag_t q_j;
  word_t    v_i;      // value when i is ready
  word_t    v_j;
  logic     i_ready;
  logic     j_ready;
  rob_tag_t rob_ix;   // tag of the instruction itself
  alu_op_t  opcode;

  modport router (
    output valid, q_i, q_j, v_i, v_j, i_ready, j_ready, rob_ix, opcode
  );

  modport station (
    input valid, q_i, q_j, v_i, v_j, i_ready, j_ready, rob_ix, opcode
  );

endinterface

`default_nettype wire

/* fu_dispatch_if.sv */
`timescale 1ns/10ps
`default_nettype none

// instruction with both operands resolved, station to alu
interface fu_dispatch_if;
  import tomasulo_pkg::*;

  logic     valid;   // registered one-cycle strobe
  word_t    rval1;
  word_t    rval2;
  alu_op_t  opcode;
  rob_tag_t rob_ix;

  modport station (
    output valid, rval1, rval2, opcode, rob_ix
  );

  modport alu (
    input valid, rval1, rval2, opcode, rob_ix
  );

endinterface

`default_nettype wire

/* issue_router.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_router #(
  parameter int NUM_LANES = tomasulo_pkg::DEFAULT_NUM_LANES
) (
  input  logic                  issue_valid,
  input  logic                  issue_i_ready,
  input  logic                  issue_j_ready,
  input  tomasulo_pkg::rob_tag_t issue_q_i,
  input  tomasulo_pkg::rob_tag_t issue_q_j,
  input  tomasulo_pkg::rob_tag_t issue_rob_ix,
  input  tomasulo_pkg::word_t    issue_v_i,
  input  tomasulo_pkg::word_t    issue_v_j,
  input  tomasulo_pkg::alu_op_t  issue_opcode,
  input  logic [NUM_LANES-1:0]  rs_free,
  output logic                  issue_ready,
  rs_issue_if.router            lane [NUM_LANES]
);

  logic [NUM_LANES-1:0] pick;  // one-hot, lowest free lane

  // isolate the lowest set bit of the free mask
  assign pick        = rs_free & ~(rs_free - 1'b1);
  assign issue_ready = |rs_free;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane[g].valid   = issue_valid & pick[g];  // only the chosen lane sees a strobe
    assign lane[g].q_i     = issue_q_i;
    assign lane[g].q_j     = issue_q_j;
    assign lane[g].v_i     = issue_v_i;
    assign lane[g].v_j     = issue_v_j;
    assign lane[g].i_ready = issue_i_ready;
    assign lane[g].j_ready = issue_j_ready;
    assign lane[g].rob_ix  = issue_rob_ix;
    assign lane[g].opcode  = issue_opcode;
  end

endmodule

`default_nettype wire

/* reservation_station.sv */
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
  parameter int RS_DEPTH = tomasulo_pkg::DEFAULT_RS_DEPTH
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  rs_issue_if.station            issue,
  input  logic                   cdb_valid,
  input  tomasulo_pkg::rob_tag_t cdb_rob_ix,
  input  tomasulo_pkg::word_t    cdb_value,
  input  logic                   fu_busy,
  output logic                   rs_free,
  fu_dispatch_if.station         dispatch
);
  import tomasulo_pkg::*;

  localparam int RW = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  typedef logic [RW-1:0] row_ix_t;

  rob_tag_t q_i_row    [RS_DEPTH];
  rob_tag_t q_j_row    [RS_DEPTH];
  word_t    v_i_row    [RS_DEPTH];
  word_t    v_j_row    [RS_DEPTH];
  rob_tag_t rob_ix_row [RS_DEPTH];
  alu_op_t  opcode_row [RS_DEPTH];

  logic [RS_DEPTH-1:0] busy_row;   // row holds an instruction
  logic [RS_DEPTH-1:0] i_ready_row;
  logic [RS_DEPTH-1:0] j_ready_row;

  row_ix_t open_row;   // lowest free row
  row_ix_t send_row;   // highest fully ready row
  logic    row_ready;
  logic    sent_last;  // dispatched in the previous cycle
  logic    do_send;

  // operands of the incoming instruction after cdb bypass
  logic    in_i_ready;
  logic    in_j_ready;
  word_t   in_v_i;
  word_t   in_v_j;

  always_comb begin
    open_row = '0;
    rs_free  = 1'b0;
    for (int r = RS_DEPTH - 1; r >= 0; r--) begin  // backwards so the lowest wins
      if (!busy_row[r]) begin
        open_row = row_ix_t'(r);
        rs_free  = 1'b1;
      end
    end

    send_row  = '0;
    row_ready = 1'b0;
    for (int r = 0; r < RS_DEPTH; r++) begin
      if (busy_row[r] && i_ready_row[r] && j_ready_row[r]) begin
        send_row  = row_ix_t'(r);
        row_ready = 1'b1;
      end
    end
  end

  assign do_send = row_ready && !fu_busy && !sent_last;

  // a broadcast in the issue cycle would otherwise be missed
  always_comb begin
    in_i_ready = issue.i_ready;
    in_v_i     = issue.v_i;
    if (!issue.i_ready && cdb_valid && cdb_rob_ix == issue.q_i) begin
      in_i_ready = 1'b1;
      in_v_i     = cdb_value;
    end
    in_j_ready = issue.j_ready;
    in_v_j     = issue.v_j;
    if (!issue.j_ready && cdb_valid && cdb_rob_ix == issue.q_j) begin
      in_j_ready = 1'b1;
      in_v_j     = cdb_value;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_row       <= '0;
      i_ready_row    <= '0;
      j_ready_row    <= '0;
      sent_last      <= 1'b0;
      dispatch.valid <= 1'b0;
    end else begin
      // wakeup of waiting rows
      if (cdb_valid) begin
        for (int r = 0; r < RS_DEPTH; r++) begin
          if (busy_row[r] && !i_ready_row[r] && q_i_row[r] == cdb_rob_ix) begin
            v_i_row[r]     <= cdb_value;
            i_ready_row[r] <= 1'b1;
          end
          if (busy_row[r] && !j_ready_row[r] && q_j_row[r] == cdb_rob_ix) begin
            v_j_row[r]     <= cdb_value;
            j_ready_row[r] <= 1'b1;
          end
        end
      end

      // router only strobes a lane with a free row
      if (issue.valid) begin
        q_i_row[open_row]     <= issue.q_i;
        q_j_row[open_row]     <= issue.q_j;
        v_i_row[open_row]     <= in_v_i;
        v_j_row[open_row]     <= in_v_j;
        i_ready_row[open_row] <= in_i_ready;
        j_ready_row[open_row] <= in_j_ready;
        rob_ix_row[open_row]  <= issue.rob_ix;
        opcode_row[open_row]  <= issue.opcode;
        busy_row[open_row]    <= 1'b1;
      end

      if (do_send) begin
        busy_row[send_row] <= 1'b0;  // never the open row, that one is idle
      end
      dispatch.valid <= do_send;
      sent_last      <= do_send;
    end
  end

  // dispatch payload, only meaningful with the strobe
  always_ff @(posedge clk_in) begin
    if (do_send) begin
      dispatch.rval1  <= v_i_row[send_row];
      dispatch.rval2  <= v_j_row[send_row];
      dispatch.opcode <= opcode_row[send_row];
      dispatch.rob_ix <= rob_ix_row[send_row];
    end
  end

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  input  logic                   clk_in,
  input  logic                   rst_in,
  fu_dispatch_if.alu             dispatch,
  input  logic                   grant,
  output logic                   busy,
  output logic                   result_valid,
  output tomasulo_pkg::rob_tag_t result_rob_ix,
  output tomasulo_pkg::word_t    result_value
);
  import tomasulo_pkg::*;

  word_t  alu_out;
  shamt_t shamt;

  assign shamt = shamt_t'(dispatch.rval2);  // only the low 5 bits shift

  always_comb begin
    case (dispatch.opcode)
      ALU_ADD:  alu_out = dispatch.rval1 + dispatch.rval2;
      ALU_SUB:  alu_out = dispatch.rval1 - dispatch.rval2;
      ALU_AND:  alu_out = dispatch.rval1 & dispatch.rval2;
      ALU_OR:   alu_out = dispatch.rval1 | dispatch.rval2;
      ALU_XOR:  alu_out = dispatch.rval1 ^ dispatch.rval2;
      ALU_SLT:  alu_out = (dispatch.rval1 < dispatch.rval2) ? 32'sd1 : 32'sd0;
      ALU_SLTU: alu_out = ($unsigned(dispatch.rval1) < $unsigned(dispatch.rval2)) ? 32'sd1 : 32'sd0;
      ALU_SLL:  alu_out = dispatch.rval1 << shamt;
      ALU_SRL:  alu_out = $signed($unsigned(dispatch.rval1) >> shamt);
      ALU_SRA:  alu_out = dispatch.rval1 >>> shamt;  // keeps the sign
      default:  alu_out = '0;
    endcase
  end

  // result waits here until the cdb takes it
  assign busy = result_valid & ~grant;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      result_valid <= 1'b0;
    end else if (dispatch.valid) begin
      result_valid <= 1'b1;  // station only sends when the slot is free
    end else if (grant) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (dispatch.valid) begin
      result_value  <= alu_out;
      result_rob_ix <= dispatch.rob_ix;
    end
  end

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter #(
  parameter int NUM_LANES = tomasulo_pkg::DEFAULT_NUM_LANES
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic [NUM_LANES-1:0]   result_valid,
  input  tomasulo_pkg::rob_tag_t result_rob_ix [NUM_LANES],
  input  tomasulo_pkg::word_t    result_value  [NUM_LANES],
  output logic [NUM_LANES-1:0]   grant,
  output logic                   cdb_valid,
  output tomasulo_pkg::rob_tag_t cdb_rob_ix,
  output tomasulo_pkg::word_t    cdb_value
);

  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  typedef logic [LW-1:0] lane_ix_t;

  lane_ix_t ptr;   // lane with first claim this cycle
  lane_ix_t sel;
  logic     found;

  // scan from the pointer and wrap around
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      idx = (int'(ptr) + k) % NUM_LANES;
      if (!found && result_valid[idx]) begin
        found = 1'b1;
        sel   = lane_ix_t'(idx);
      end
    end
    grant = '0;
    if (found) begin
      grant[sel] = 1'b1;
    end
  end

  assign cdb_valid  = found;
  assign cdb_rob_ix = result_rob_ix[sel];
  assign cdb_value  = result_value[sel];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= (sel == lane_ix_t'(NUM_LANES - 1)) ? '0 : sel + 1'b1;  // next lane after the winner
    end
  end

endmodule

`default_nettype wire

/* tomasulo_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module tomasulo_cluster #(
  parameter int NUM_LANES = tomasulo_pkg::DEFAULT_NUM_LANES,
  parameter int RS_DEPTH  = tomasulo_pkg::DEFAULT_RS_DEPTH
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   issue_valid,
  input  logic                   issue_i_ready,
  input  logic                   issue_j_ready,
  input  tomasulo_pkg::rob_tag_t issue_q_i,
  input  tomasulo_pkg::rob_tag_t issue_q_j,
  input  tomasulo_pkg::rob_tag_t issue_rob_ix,
  input  tomasulo_pkg::word_t    issue_v_i,
  input  tomasulo_pkg::word_t    issue_v_j,
  input  tomasulo_pkg::alu_op_t  issue_opcode,
  output logic                   issue_ready,
  output logic                   cdb_valid,
  output tomasulo_pkg::rob_tag_t cdb_rob_ix,
  output tomasulo_pkg::word_t    cdb_value
);
  import tomasulo_pkg::*;

  logic [NUM_LANES-1:0] rs_free;
  logic [NUM_LANES-1:0] fu_busy;
  logic [NUM_LANES-1:0] result_valid;
  logic [NUM_LANES-1:0] grant;
  rob_tag_t             result_rob_ix [NUM_LANES];
  word_t                result_value  [NUM_LANES];

  rs_issue_if    issue_bus [NUM_LANES] ();
  fu_dispatch_if disp_bus  [NUM_LANES] ();

  issue_router #(.NUM_LANES(NUM_LANES)) u_router (
    .issue_valid   (issue_valid),
    .issue_i_ready (issue_i_ready),
    .issue_j_ready (issue_j_ready),
    .issue_q_i     (issue_q_i),
    .issue_q_j     (issue_q_j),
    .issue_rob_ix  (issue_rob_ix),
    .issue_v_i     (issue_v_i),
    .issue_v_j     (issue_v_j),
    .issue_opcode  (issue_opcode),
    .rs_free       (rs_free),
    .issue_ready   (issue_ready),
    .lane          (issue_bus)
  );

  // one station feeding one alu per lane
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
      .clk_in     (clk_in),
      .rst_in     (rst_in),
      .issue      (issue_bus[g]),
      .cdb_valid  (cdb_valid),
      .cdb_rob_ix (cdb_rob_ix),
      .cdb_value  (cdb_value),
      .fu_busy    (fu_busy[g]),
      .rs_free    (rs_free[g]),
      .dispatch   (disp_bus[g])
    );

    alu_unit u_alu (
      .clk_in        (clk_in),
      .rst_in        (rst_in),
      .dispatch      (disp_bus[g]),
      .grant         (grant[g]),
      .busy          (fu_busy[g]),
      .result_valid  (result_valid[g]),
      .result_rob_ix (result_rob_ix[g]),
      .result_value  (result_value[g])
    );
  end

  cdb_arbiter #(.NUM_LANES(NUM_LANES)) u_arbiter (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .result_valid  (result_valid),
    .result_rob_ix (result_rob_ix),
    .result_value  (result_value),
    .grant         (grant),
    .cdb_valid     (cdb_valid),
    .cdb_rob_ix    (cdb_rob_ix),
    .cdb_value     (cdb_value)
  );

endmodule

`default_nettype wire

/* tb_tomasulo_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tomasulo_cluster;
  import tomasulo_pkg::*;

  localparam int NL           = DEFAULT_NUM_LANES;
  localparam int DEPTH        = DEFAULT_RS_DEPTH;
  localparam int NUM_TAGS     = 8;
  localparam int RAND_COUNT   = 60;
  localparam int TOTAL_ISSUES = 10 + 5 + NL * DEPTH + RAND_COUNT;
  localparam int CYCLE_LIMIT  = 40 * TOTAL_ISSUES + 200;

  logic     clk_in;
  logic     rst_in;
  logic     issue_valid;
  logic     issue_i_ready;
  logic     issue_j_ready;
  rob_tag_t issue_q_i;
  rob_tag_t issue_q_j;
  rob_tag_t issue_rob_ix;
  word_t    issue_v_i;
  word_t    issue_v_j;
  alu_op_t  issue_opcode;
  logic     issue_ready;
  logic     cdb_valid;
  rob_tag_t cdb_rob_ix;
  word_t    cdb_value;

  // one entry per instruction issued but not yet broadcast
  rob_tag_t pend_tag [$];
  word_t    pend_val [$];
  word_t    tag_val  [NUM_TAGS];  // expected result of the latest instruction per tag
  int       seen_at  [NUM_TAGS];  // cycle of the last broadcast per tag
  int       cycle = 0;

  tomasulo_cluster #(.NUM_LANES(NL), .RS_DEPTH(DEPTH)) UUT (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .issue_valid   (issue_valid),
    .issue_i_ready (issue_i_ready),
    .issue_j_ready (issue_j_ready),
    .issue_q_i     (issue_q_i),
    .issue_q_j     (issue_q_j),
    .issue_rob_ix  (issue_rob_ix),
    .issue_v_i     (issue_v_i),
    .issue_v_j     (issue_v_j),
    .issue_opcode  (issue_opcode),
    .issue_ready   (issue_ready),
    .cdb_valid     (cdb_valid),
    .cdb_rob_ix    (cdb_rob_ix),
    .cdb_value     (cdb_value)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycle <= cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results never broadcast", cycle, pend_tag.size());
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic stop_with(string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic stop_on_mismatch(string sig, word_t exp, word_t act);
    $display("FAILED %s expected %08h actual %08h", sig, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "value mismatch");
  endtask

  // shifts use the low 5 bits of b and compares give 1 or 0
  function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
    logic [31:0] ua;
    logic [31:0] ub;
    int          sh;
    ua = a;
    ub = b;
    sh = int'(ub[4:0]);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return (a < b) ? 32'sd1 : 32'sd0;
      ALU_SLTU: return (ua < ub) ? 32'sd1 : 32'sd0;
      ALU_SLL:  return word_t'(ua << sh);
      ALU_SRL:  return word_t'(ua >> sh);
      ALU_SRA:  return a >>> sh;
      default:  return 32'sd0;
    endcase
  endfunction

  function automatic int find_pending(rob_tag_t tag);
    for (int k = 0; k < pend_tag.size(); k++) begin
      if (pend_tag[k] == tag) return k;
    end
    return -1;
  endfunction

  function automatic int find_match(rob_tag_t tag, word_t val);
    for (int k = 0; k < pend_tag.size(); k++) begin
      if (pend_tag[k] == tag && pend_val[k] == val) return k;
    end
    return -1;
  endfunction

  function automatic word_t random_word();
    int unsigned pick;
    pick = $urandom_range(3, 0);
    if (pick == 0) return word_t'($urandom_range(40, 0)) - 32'sd20;  // small and often negative
    return word_t'($urandom());
  endfunction

  // every broadcast must retire one outstanding instruction
  always @(negedge clk_in) begin : cdb_monitor
    int any;
    int hit;
    if (!rst_in && cdb_valid) begin
      any = find_pending(cdb_rob_ix);
      hit = find_match(cdb_rob_ix, cdb_value);
      assert (any >= 0)
        else stop_with($sformatf("unexpected tag %0d on the CDB", cdb_rob_ix));
      assert (hit >= 0) else stop_on_mismatch("cdb_value", pend_val[any], cdb_value);
      pend_tag.delete(hit);
      pend_val.delete(hit);
      seen_at[cdb_rob_ix] = cycle;
    end
  end

  task automatic next_cycle();
    @(posedge clk_in);
    #1;
  endtask

  task automatic wait_for_slot();
    while (!issue_ready) next_cycle();
  endtask

  // waits until some tag has no result outstanding
  task automatic alloc_tag(output rob_tag_t tag);
    bit found;
    int start;
    found = 0;
    tag   = '0;
    start = $urandom_range(NUM_TAGS - 1, 0);
    while (!found) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (!found && find_pending(rob_tag_t'((start + t) % NUM_TAGS)) < 0) begin
          tag   = rob_tag_t'((start + t) % NUM_TAGS);
          found = 1;
        end
      end
      if (!found) next_cycle();
    end
  endtask

  // a waiting operand takes the value expected for its producer tag
  task automatic send_instr(alu_op_t op, rob_tag_t tag,
                            logic i_rdy, word_t i_val, rob_tag_t i_src,
                            logic j_rdy, word_t j_val, rob_tag_t j_src);
    word_t a;
    word_t b;
    wait_for_slot();
    a = i_rdy ? i_val : tag_val[i_src];
    b = j_rdy ? j_val : tag_val[j_src];
    issue_valid   = 1'b1;
    issue_opcode  = op;
    issue_rob_ix  = tag;
    issue_i_ready = i_rdy;
    issue_v_i     = i_val;
    issue_q_i     = i_src;
    issue_j_ready = j_rdy;
    issue_v_j     = j_val;
    issue_q_j     = j_src;
    tag_val[tag]  = model_alu(op, a, b);
    pend_tag.push_back(tag);
    pend_val.push_back(tag_val[tag]);
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic send_ready(alu_op_t op, word_t a, word_t b);
    rob_tag_t tag;
    alloc_tag(tag);
    send_instr(op, tag, 1'b1, a, '0, 1'b1, b, '0);
  endtask

  task automatic drain_all(string name);
    while (pend_tag.size() != 0) next_cycle();
    repeat (4) next_cycle();  // room for a stray second broadcast to show up
    $display("%s done at cycle %0d", name, cycle);
  endtask

  task automatic test_reset_state();
    assert (issue_ready === 1'b1) else stop_on_mismatch("issue_ready", 1, word_t'(issue_ready));
    repeat (10) begin
      next_cycle();
      assert (cdb_valid === 1'b0) else stop_on_mismatch("cdb_valid", 0, word_t'(cdb_valid));
    end
    $display("reset state done");
  endtask

  task automatic test_all_functions();
    send_ready(ALU_ADD,  -32'sd7,       32'sd12);
    send_ready(ALU_SUB,  32'sd5,        32'sd9);
    send_ready(ALU_AND,  32'hF0F01234,  32'h0FF0FFFF);
    send_ready(ALU_OR,   -32'sd256,     32'sh7F);
    send_ready(ALU_XOR,  32'hAAAA5555,  -32'sd1);
    send_ready(ALU_SLT,  -32'sd3,       32'sd2);
    send_ready(ALU_SLTU, -32'sd3,       32'sd2);   // negative is large unsigned
    send_ready(ALU_SLL,  32'sd1,        32'sd35);
    send_ready(ALU_SRL,  -32'sd16,      32'sd36);
    send_ready(ALU_SRA,  -32'sd16,      32'sd63);
    drain_all("all functions");
  endtask

  task automatic test_dependency_chain();
    for (int t = 0; t < 5; t++) seen_at[t] = -1;
    send_instr(ALU_ADD, 3'd0, 1'b1, 32'sd100, '0, 1'b1, -32'sd30, '0);
    send_instr(ALU_SUB, 3'd1, 1'b0, '0, 3'd0, 1'b1, 32'sd5, '0);
    send_instr(ALU_ADD, 3'd2, 1'b0, '0, 3'd1, 1'b0, '0, 3'd1);  // both operands wait
    send_instr(ALU_SLL, 3'd3, 1'b0, '0, 3'd2, 1'b1, 32'sd3, '0);
    send_instr(ALU_SRA, 3'd4, 1'b1, -32'sd4096, '0, 1'b0, '0, 3'd3);
    drain_all("dependency chain");
    for (int k = 1; k < 5; k++) begin
      assert (seen_at[k] > seen_at[k - 1] && seen_at[k - 1] >= 0)
        else stop_with($sformatf("tag %0d was broadcast before tag %0d", k, k - 1));
    end
  endtask

  // every row waits on the producer, which itself takes the last free row
  task automatic test_full_cluster();
    rob_tag_t prod;
    rob_tag_t wtag;
    int       waiters;
    prod          = rob_tag_t'(NUM_TAGS - 1);
    tag_val[prod] = model_alu(ALU_ADD, 32'sd1000, 32'sd234);
    waiters       = NL * DEPTH - 1;
    for (int n = 0; n < waiters; n++) begin
      wtag = rob_tag_t'(n % (NUM_TAGS - 1));
      send_instr(alu_op_t'(4'(n % 10)), wtag, 1'b0, '0, prod, 1'b1, word_t'(n * 3 - 7), '0);
      assert (issue_ready === 1'b1)
        else stop_on_mismatch("issue_ready", 1, word_t'(issue_ready));
    end
    send_instr(ALU_ADD, prod, 1'b1, 32'sd1000, '0, 1'b1, 32'sd234, '0);
    assert (issue_ready === 1'b0) else stop_on_mismatch("issue_ready", 0, word_t'(issue_ready));
    drain_all("full cluster");
  endtask

  task automatic test_random_traffic();
    rob_tag_t tag;
    rob_tag_t live [$];
    rob_tag_t i_src;
    rob_tag_t j_src;
    logic     i_rdy;
    logic     j_rdy;
    alu_op_t  op;
    for (int n = 0; n < RAND_COUNT; n++) begin
      alloc_tag(tag);
      wait_for_slot();
      live  = pend_tag;  // only producers still in flight can be waited on
      op    = alu_op_t'(4'($urandom_range(9, 0)));
      i_rdy = (live.size() == 0) || ($urandom_range(2, 0) != 0);
      j_rdy = (live.size() == 0) || ($urandom_range(2, 0) != 0);
      i_src = '0;
      j_src = '0;
      if (!i_rdy) i_src = live[$urandom_range(live.size() - 1, 0)];
      if (!j_rdy) j_src = live[$urandom_range(live.size() - 1, 0)];
      send_instr(op, tag, i_rdy, random_word(), i_src, j_rdy, random_word(), j_src);
    end
    drain_all("random traffic");
  endtask

  initial begin
    void'($urandom(9));
    rst_in        = 1'b1;
    issue_valid   = 1'b0;
    issue_i_ready = 1'b1;
    issue_j_ready = 1'b1;
    issue_q_i     = '0;
    issue_q_j     = '0;
    issue_rob_ix  = '0;
    issue_v_i     = '0;
    issue_v_j     = '0;
    issue_opcode  = ALU_ADD;
    for (int t = 0; t < NUM_TAGS; t++) begin
      tag_val[t] = '0;
      seen_at[t] = -1;
    end
    repeat (5) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    test_reset_state();
    test_all_functions();
    test_dependency_chain();
    test_full_cluster();
    test_random_traffic();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tomasulo_cluster.f */
tomasulo_pkg.sv
rs_issue_if.sv
fu_dispatch_if.sv
issue_router.sv
reservation_station.sv
alu_unit.sv
cdb_arbiter.sv
tomasulo_cluster.sv
tb_tomasulo_cluster.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       := tb_tomasulo_cluster
FILELIST  := tomasulo_cluster.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
